//--- design/bp_pkg.sv
package bp_pkg;

    // Instruction address
    typedef logic [31:0] pc_t;

    // Kind of instruction in execute
    // Bit 0 marks a conditional branch, bit 1 an unconditional jump
    typedef logic [1:0] branch_op_t;

    localparam branch_op_t BRANCH_OP_NONE = 2'b00;
    localparam branch_op_t BRANCH_OP_COND = 2'b01;
    localparam branch_op_t BRANCH_OP_JUMP = 2'b10;

    // Global history pattern
    // Bit 0 is the latest outcome, bit 1 the one before it
    typedef logic [1:0] local_src_t;

    // Two-bit saturating counter
    // Top bit set means predict taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_t;

    // Number of counters per index, one for each history pattern
    localparam int HISTORY_PATTERNS = 4;

    // First PC bit used for table indexing
    localparam int INDEX_LSB = 2;

endpackage

//--- design/bp_update_if.sv
interface bp_update_if;

    // Execute stage is stalled, hold everything
    logic               stall_e;
    // Kind of instruction being resolved
    bp_pkg::branch_op_t branch_op_e;
    // Resolved outcome, high when taken
    logic               pc_src_res_e;
    // Address of the resolved instruction
    bp_pkg::pc_t        pc_e;
    // Resolved target address
    bp_pkg::pc_t        target_e;

    // Execute stage side
    modport exec (
        output stall_e,
        output branch_op_e,
        output pc_src_res_e,
        output pc_e,
        output target_e
    );

    // Predictor blocks, read only
    modport pred (
        input stall_e,
        input branch_op_e,
        input pc_src_res_e,
        input pc_e,
        input target_e
    );

endinterface

//--- design/branch_predictor.sv
module branch_predictor #(
    parameter int INDEX_BITS = 4
) (
    input  logic               clk_i,
    input  logic               reset_i,

    // Fetch stage lookup
    input  bp_pkg::pc_t        pc_f_i,

    // Execute stage resolution
    input  logic               stall_e_i,
    input  bp_pkg::branch_op_t branch_op_e_i,
    input  logic               pc_src_res_e_i,
    input  bp_pkg::pc_t        pc_e_i,
    input  bp_pkg::pc_t        target_e_i,

    // Prediction back to fetch
    output logic               pred_taken_f_o,
    output bp_pkg::pc_t        pred_target_f_o
);

    bp_update_if upd ();

    bp_pkg::local_src_t local_src;
    logic               counter_taken;
    logic               btb_hit;
    logic               btb_is_jump;
    bp_pkg::pc_t        btb_target;

    // Execute ports onto the shared update bus
    assign upd.stall_e      = stall_e_i;
    assign upd.branch_op_e  = branch_op_e_i;
    assign upd.pc_src_res_e = pc_src_res_e_i;
    assign upd.pc_e         = pc_e_i;
    assign upd.target_e     = target_e_i;

    ghr u_ghr (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .upd         (upd),
        .local_src_o (local_src)
    );

    pattern_table #(
        .INDEX_BITS (INDEX_BITS)
    ) u_pattern_table (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .upd             (upd),
        .local_src_i     (local_src),
        .pc_f_i          (pc_f_i),
        .counter_taken_o (counter_taken)
    );

    branch_target_buffer #(
        .INDEX_BITS (INDEX_BITS)
    ) u_btb (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .upd       (upd),
        .pc_f_i    (pc_f_i),
        .hit_o     (btb_hit),
        .is_jump_o (btb_is_jump),
        .target_o  (btb_target)
    );

    // Need a BTB hit, then jumps always go, branches follow the counter
    assign pred_taken_f_o  = btb_hit & (btb_is_jump | counter_taken);
    // BTB already gives zero on a miss
    assign pred_target_f_o = btb_target;

endmodule

//--- design/branch_target_buffer.sv
module branch_target_buffer #(
    parameter int INDEX_BITS = 4
) (
    input  logic        clk_i,
    input  logic        reset_i,
    bp_update_if.pred   upd,
    input  bp_pkg::pc_t pc_f_i,
    output logic        hit_o,
    output logic        is_jump_o,
    output bp_pkg::pc_t target_o
);

    localparam int NUM_ENTRIES = 1 << INDEX_BITS;
    localparam int TAG_LSB     = bp_pkg::INDEX_LSB + INDEX_BITS;
    localparam int TAG_BITS    = 32 - TAG_LSB;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    // Valid bits are control state
    logic [NUM_ENTRIES-1:0] valid;

    // Entry payload
    tag_t        tags    [NUM_ENTRIES];
    bp_pkg::pc_t targets [NUM_ENTRIES];
    logic        jumps   [NUM_ENTRIES];

    index_t rd_idx;
    tag_t   rd_tag;
    index_t wr_idx;
    tag_t   wr_tag;
    logic   wr_en;

    // Fetch side split of the PC
    assign rd_idx = pc_f_i[bp_pkg::INDEX_LSB +: INDEX_BITS];
    assign rd_tag = pc_f_i[TAG_LSB +: TAG_BITS];

    // Execute side split of the PC
    assign wr_idx = upd.pc_e[bp_pkg::INDEX_LSB +: INDEX_BITS];
    assign wr_tag = upd.pc_e[TAG_LSB +: TAG_BITS];

    // Only taken branches and jumps allocate
    // Not taken leaves the entry alone
    assign wr_en = ~upd.stall_e & upd.pc_src_res_e
                 & (upd.branch_op_e != bp_pkg::BRANCH_OP_NONE);

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // Overwrites any alias sitting at the same index
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            tags[wr_idx]    <= wr_tag;
            targets[wr_idx] <= upd.target_e;
            jumps[wr_idx]   <= upd.branch_op_e[1];
        end
    end

    // Lookup
    assign hit_o     = valid[rd_idx] & (tags[rd_idx] == rd_tag);
    assign is_jump_o = hit_o & jumps[rd_idx];
    // Zero target on a miss
    assign target_o  = hit_o ? targets[rd_idx] : '0;

    // Misses never leak a stale target
    a_miss_zero: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !hit_o |-> (target_o == '0)
    ) else $error("btb target nonzero on miss");

endmodule

//--- design/ghr.sv
module ghr (
    input  logic               clk_i,
    input  logic               reset_i,
    bp_update_if.pred          upd,
    output bp_pkg::local_src_t local_src_o
);

    // History states, named older outcome first
    // U is untaken, T is taken
    typedef enum logic [1:0] {
        UU = 2'b00,
        UT = 2'b01,
        TU = 2'b10,
        TT = 2'b11
    } ghr_state_t;

    ghr_state_t state;
    ghr_state_t state_next;

    // Only unstalled conditional branches move the history
    logic shift_en;

    assign shift_en = upd.branch_op_e[0] & ~upd.stall_e;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state <= UT;
        end else begin
            state <= state_next;
        end
    end

    // Old bit 0 moves up, outcome enters at bit 0
    always_comb begin
        state_next = state;
        if (shift_en) begin
            case (state)
                UU, TU:  state_next = upd.pc_src_res_e ? UT : UU;
                UT, TT:  state_next = upd.pc_src_res_e ? TT : TU;
                default: state_next = UT;
            endcase
        end
    end

    // Encoding doubles as the counter select
    assign local_src_o = bp_pkg::local_src_t'(state);

    // History must never go unknown once out of reset
    a_state_known: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !$isunknown(state)
    ) else $error("ghr state is unknown");

endmodule

//--- design/pattern_table.sv
module pattern_table #(
    parameter int INDEX_BITS = 4
) (
    input  logic               clk_i,
    input  logic               reset_i,
    bp_update_if.pred          upd,
    input  bp_pkg::local_src_t local_src_i,
    input  bp_pkg::pc_t        pc_f_i,
    output logic               counter_taken_o
);

    localparam int NUM_SETS = 1 << INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;

    // One set of counters per index, one counter per history pattern
    bp_pkg::counter_t [NUM_SETS-1:0][bp_pkg::HISTORY_PATTERNS-1:0] counters;

    index_t           rd_idx;
    index_t           wr_idx;
    bp_pkg::counter_t rd_cnt;
    bp_pkg::counter_t wr_cnt;
    bp_pkg::counter_t wr_cnt_next;
    logic             train_en;

    // Fetch lookup
    assign rd_idx = pc_f_i[bp_pkg::INDEX_LSB +: INDEX_BITS];
    assign rd_cnt = counters[rd_idx][local_src_i];

    // Top bit of the counter is the direction
    assign counter_taken_o = rd_cnt[1];

    // Execute training, same history as the lookup
    assign wr_idx   = upd.pc_e[bp_pkg::INDEX_LSB +: INDEX_BITS];
    assign wr_cnt   = counters[wr_idx][local_src_i];
    assign train_en = upd.branch_op_e[0] & ~upd.stall_e;

    // Step toward the outcome, saturate at both ends
    always_comb begin
        wr_cnt_next = wr_cnt;
        if (upd.pc_src_res_e) begin
            if (wr_cnt != bp_pkg::STRONG_T) begin
                wr_cnt_next = bp_pkg::counter_t'(wr_cnt + 2'd1);
            end
        end else begin
            if (wr_cnt != bp_pkg::STRONG_NT) begin
                wr_cnt_next = bp_pkg::counter_t'(wr_cnt - 2'd1);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            // Everything starts weakly not taken
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int h = 0; h < bp_pkg::HISTORY_PATTERNS; h++) begin
                    counters[s][h] <= bp_pkg::WEAK_NT;
                end
            end
        end else if (train_en) begin
            counters[wr_idx][local_src_i] <= wr_cnt_next;
        end
    end

    // Stalled execute leaves the whole table untouched
    a_stall_holds: assert property (
        @(posedge clk_i) disable iff (reset_i)
        upd.stall_e |=> $stable(counters)
    ) else $error("pattern table changed during stall");

endmodule

//--- run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module branch_predictor_tb \
    -Mdir obj_dir -o branch_predictor_sim

status=0
./obj_dir/branch_predictor_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || ! grep -q "^STATUS: PASS$" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- testbench/branch_predictor_tb.sv
module branch_predictor_tb;

    localparam int INDEX_BITS   = 4;
    localparam int NUM_SETS     = 1 << INDEX_BITS;
    // Index sits above the byte offset, tag above the index
    localparam int IDX_LSB      = 2;
    localparam int TAG_LSB      = IDX_LSB + INDEX_BITS;
    localparam int RESET_CYCLES = 8;
    // Driven cycles of the six tests, plus two closing cycles each
    localparam int TEST_CYCLES    = 20 + 6 + 20 + 12 + 16 + 48 + 6 * 2;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + RESET_CYCLES;

    typedef logic [31-TAG_LSB:0] tag_t;
    typedef struct packed {
        logic        taken;
        bp_pkg::pc_t target;
    } prediction_t;

    logic               clk_i;
    logic               reset_i;
    bp_pkg::pc_t        pc_f;
    logic               stall_e;
    bp_pkg::branch_op_t branch_op;
    logic               pc_src_res;
    bp_pkg::pc_t        pc_e;
    bp_pkg::pc_t        target_e;
    logic               pred_taken;
    bp_pkg::pc_t        pred_target;

    // Reference history, counters and BTB
    logic [1:0]       m_hist;
    bp_pkg::counter_t m_cnt    [NUM_SETS][4];
    logic             m_valid  [NUM_SETS];
    tag_t             m_tag    [NUM_SETS];
    bp_pkg::pc_t      m_target [NUM_SETS];
    logic             m_jump   [NUM_SETS];

    logic [31:0] lfsr_state = 32'd93218;
    string       test_name;
    int          test_errors, error_count, check_count, tests_failed, cycle_count;

    branch_predictor #(
        .INDEX_BITS (INDEX_BITS)
    ) dut_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .pc_f_i          (pc_f),
        .stall_e_i       (stall_e),
        .branch_op_e_i   (branch_op),
        .pc_src_res_e_i  (pc_src_res),
        .pc_e_i          (pc_e),
        .target_e_i      (target_e),
        .pred_taken_f_o  (pred_taken),
        .pred_target_f_o (pred_target)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]}
                       ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic bp_pkg::pc_t rand_pc();
        logic [31:0] r;
        r = rand_bits(30);
        return {r[29:0], 2'b00};
    endfunction

    // Fixed page, two tag bits and two index bits, so entries collide often
    function automatic bp_pkg::pc_t alias_pc();
        logic [31:0] r;
        r = rand_bits(4);
        return {24'h000010, r[3:2], 2'b00, r[1:0], 2'b00};
    endfunction

    // Expected fetch answer from the reference arrays
    function automatic prediction_t model_predict(input bp_pkg::pc_t pc);
        logic [INDEX_BITS-1:0] idx;
        prediction_t           p;
        idx = pc[IDX_LSB +: INDEX_BITS];
        p   = '0;
        // Hit needs valid and tag, then jump flag or counter top bit
        if (m_valid[idx] && m_tag[idx] == pc[31:TAG_LSB]) begin
            p.taken  = m_jump[idx] | m_cnt[idx][m_hist][1];
            p.target = m_target[idx];
        end
        return p;
    endfunction

    // Reference update for one clock edge
    function automatic void model_update(input logic stall, input bp_pkg::branch_op_t op,
                                         input logic taken, input bp_pkg::pc_t pc,
                                         input bp_pkg::pc_t tgt);
        logic [INDEX_BITS-1:0] idx;
        bp_pkg::counter_t      c;
        idx = pc[IDX_LSB +: INDEX_BITS];
        if (stall) return;
        if (op[0]) begin
            // One step toward the outcome, saturating
            c = m_cnt[idx][m_hist];
            case (c)
                bp_pkg::STRONG_NT: c = taken ? bp_pkg::WEAK_NT : bp_pkg::STRONG_NT;
                bp_pkg::WEAK_NT:   c = taken ? bp_pkg::WEAK_T : bp_pkg::STRONG_NT;
                bp_pkg::WEAK_T:    c = taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_NT;
                default:           c = taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_T;
            endcase
            m_cnt[idx][m_hist] = c;
            m_hist = {m_hist[0], taken};
        end
        // Taken branches and jumps allocate, replacing any alias
        if (taken && op != bp_pkg::BRANCH_OP_NONE) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = pc[31:TAG_LSB];
            m_target[idx] = tgt;
            m_jump[idx]   = op[1];
        end
    endfunction

    task automatic check_taken(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            test_errors++;
            $display("Mismatch in %s: pred_taken expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_target(input string name, input bp_pkg::pc_t exp,
                                input bp_pkg::pc_t act);
        check_count++;
        if (act !== exp) begin
            test_errors++;
            $display("Mismatch in %s: pred_target expected %h, actual %h", name, exp, act);
        end
    endtask

    // Inputs change one unit after the rising edge
    task automatic drive_cycle(input bp_pkg::pc_t fetch, input logic stall,
                               input bp_pkg::branch_op_t op, input logic taken,
                               input bp_pkg::pc_t pc, input bp_pkg::pc_t tgt);
        @(posedge clk_i);
        #1;
        pc_f       = fetch;
        stall_e    = stall;
        branch_op  = op;
        pc_src_res = taken;
        pc_e       = pc;
        target_e   = tgt;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    // One idle cycle, then the result line
    task automatic end_test();
        drive_cycle(pc_f, 1'b0, bp_pkg::BRANCH_OP_NONE, 1'b0, 32'h0, 32'h0);
        @(posedge clk_i);
        error_count += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %s: %0d errors", test_name, test_errors);
    endtask

    // Samples one unit before each rising edge, then steps the model
    initial begin : compare
        prediction_t expected;
        m_hist = 2'b01;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[s] = 1'b0;
            for (int h = 0; h < 4; h++) begin
                m_cnt[s][h] = bp_pkg::WEAK_NT;
            end
        end
        @(negedge reset_i);
        forever begin
            @(negedge clk_i);
            #1;
            expected = model_predict(pc_f);
            check_taken(test_name, expected.taken, pred_taken);
            check_target(test_name, expected.target, pred_target);
            model_update(stall_e, branch_op, pc_src_res, pc_e, target_e);
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : stimulus
        bp_pkg::pc_t br_pc;
        bp_pkg::pc_t br_tgt;
        bp_pkg::pc_t jmp_pc;
        logic        outcome;
        pc_f         = '0;
        stall_e      = 1'b0;
        branch_op    = bp_pkg::BRANCH_OP_NONE;
        pc_src_res   = 1'b0;
        pc_e         = '0;
        target_e     = '0;
        test_name    = "reset";
        error_count  = 0;
        check_count  = 0;
        tests_failed = 0;
        test_errors  = 0;
        reset_i      = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // Nothing trained, every fetch misses
        start_test("reset_state");
        repeat (20) drive_cycle(rand_pc(), 1'b0, bp_pkg::BRANCH_OP_NONE, 1'b0, 32'h0, 32'h0);
        end_test();

        start_test("cond_training");
        br_pc  = rand_pc();
        br_tgt = rand_pc();
        repeat (2) drive_cycle(br_pc, 1'b0, bp_pkg::BRANCH_OP_COND, 1'b1, br_pc, br_tgt);
        repeat (4) drive_cycle(br_pc, 1'b0, bp_pkg::BRANCH_OP_NONE, 1'b0, 32'h0, 32'h0);
        end_test();

        // Alternating outcome spreads over the history patterns
        start_test("history_select");
        br_pc   = rand_pc();
        br_tgt  = rand_pc();
        outcome = 1'b1;
        for (int i = 0; i < 16; i++) begin
            drive_cycle(br_pc, 1'b0, bp_pkg::BRANCH_OP_COND, outcome, br_pc, br_tgt);
            outcome = ~outcome;
        end
        repeat (4) drive_cycle(br_pc, 1'b0, bp_pkg::BRANCH_OP_NONE, 1'b0, 32'h0, 32'h0);
        end_test();

        start_test("jumps");
        for (int i = 0; i < 4; i++) begin
            jmp_pc = rand_pc();
            drive_cycle(jmp_pc, 1'b0, bp_pkg::BRANCH_OP_JUMP, 1'b1, jmp_pc, rand_pc());
            repeat (2) drive_cycle(jmp_pc, 1'b0, bp_pkg::BRANCH_OP_NONE, 1'b0, 32'h0, 32'h0);
        end
        end_test();

        // Random resolutions under stall, then fetches of trained PCs
        start_test("stall");
        for (int i = 0; i < 12; i++) begin
            drive_cycle(br_pc, 1'b1, bp_pkg::branch_op_t'(rand_bits(2)), 1'(rand_bits(1)),
                        i[0] ? br_pc : rand_pc(), rand_pc());
        end
        repeat (2) begin
            drive_cycle(br_pc, 1'b0, bp_pkg::BRANCH_OP_NONE, 1'b0, 32'h0, 32'h0);
            drive_cycle(jmp_pc, 1'b0, bp_pkg::BRANCH_OP_NONE, 1'b0, 32'h0, 32'h0);
        end
        end_test();

        start_test("aliasing");
        repeat (48) begin
            drive_cycle(alias_pc(), 1'b0, bp_pkg::branch_op_t'(rand_bits(2)),
                        1'(rand_bits(1)), alias_pc(), rand_pc());
        end
        end_test();

        $display("Summary: 6 tests, %0d failed, %0d checks, %0d errors",
                 tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/bp_pkg.sv
design/bp_update_if.sv
design/ghr.sv
design/pattern_table.sv
design/branch_target_buffer.sv
design/branch_predictor.sv
testbench/branch_predictor_tb.sv
